/* common/sbox_pkg.sv */
package sbox_pkg;

  // field element of gf(2^6) in the outer polynomial basis.
  typedef logic [5:0] gf64_t;

  // gf(4) digit in normal basis, three of them make one composite-field element.
  typedef logic [1:0] gf4_t;

  localparam int NUM_LANES = 4;

  typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;

  // Row k selects the input bits whose xor gives output bit k.
  localparam gf64_t ISO_ROWS [6] = '{
    6'b000001,  // b0 = a0.
    6'b011001,  // b1 = a0 ^ a3 ^ a4.
    6'b011010,  // b2 = a1 ^ a3 ^ a4.
    6'b101011,  // b3 = a0 ^ a1 ^ a3 ^ a5.
    6'b101101,  // b4 = a0 ^ a2 ^ a3 ^ a5.
    6'b001100   // b5 = a2 ^ a3.
  };

  // maps gf((2^2)^3) back into the polynomial basis.
  localparam gf64_t INV_ISO_ROWS [6] = '{
    6'b111110,  // b0 = a1 ^ a2 ^ a3 ^ a4 ^ a5.
    6'b011111,  // b1 = a0 ^ a1 ^ a2 ^ a3 ^ a4.
    6'b100111,  // b2 = a0 ^ a1 ^ a2 ^ a5.
    6'b011101,  // b3 = a0 ^ a2 ^ a3 ^ a4.
    6'b010010,  // b4 = a1 ^ a4.
    6'b010001   // b5 = a0 ^ a4.
  };

endpackage

/* gf_power/gf64_power40.sv */
`timescale 1ns/1ps

module gf64_power40 import sbox_pkg::*; (
  input  gf64_t x,
  output gf64_t y
);

  // Linear change of basis, one xor tree per output bit.
  function automatic gf64_t lin_map(input gf64_t rows [6], input gf64_t a);
    gf64_t r;
    for (int k = 0; k < 6; k++) begin
      r[k] = ^(rows[k] & a);
    end
    return r;
  endfunction

  // squaring in a normal basis is a swap of the two coordinates.
  function automatic gf4_t gf4_sq(input gf4_t a);
    return {a[0], a[1]};
  endfunction

  function automatic gf4_t gf4_mul(input gf4_t a, input gf4_t b);
    logic t;
    t = (a[0] & b[1]) ^ (a[1] & b[0]);  // shared cross term.
    return {(a[0] & b[0]) ^ t, (a[1] & b[1]) ^ t};
  endfunction

  // c selects the constant: 0, 1, the generator or the generator squared.
  function automatic gf4_t gf4_cmul(input gf4_t a, input logic [1:0] c);
    gf4_t r;
    case (c)
      2'd0: r = '0;
      2'd1: r = a;
      2'd2: r = {a[0] ^ a[1], a[1]};
      default: r = {a[0], a[0] ^ a[1]};
    endcase
    return r;
  endfunction

  gf64_t w;
  gf64_t p;
  gf4_t  d [3];
  gf4_t  s [3];
  gf4_t  t [6];
  gf4_t  z [3];

  assign w = lin_map(ISO_ROWS, x);

  assign d[0] = w[1:0];
  assign d[1] = w[3:2];
  assign d[2] = w[5:4];

  assign s[0] = gf4_sq(d[0]);
  assign s[1] = gf4_sq(d[1]);
  assign s[2] = gf4_sq(d[2]);

  // Six terms feed the output digits: the digits and the pairwise products of squares.
  assign t[0] = d[0];
  assign t[1] = d[1];
  assign t[2] = d[2];
  assign t[3] = gf4_mul(s[0], s[1]);
  assign t[4] = gf4_mul(s[0], s[2]);
  assign t[5] = gf4_mul(s[1], s[2]);

  assign z[0] = gf4_cmul(t[0], 2'd1) ^ gf4_cmul(t[1], 2'd2) ^
                gf4_cmul(t[2], 2'd0) ^ gf4_cmul(t[3], 2'd1) ^
                gf4_cmul(t[4], 2'd2) ^ gf4_cmul(t[5], 2'd0);

  assign z[1] = gf4_cmul(t[0], 2'd0) ^ gf4_cmul(t[1], 2'd2) ^
                gf4_cmul(t[2], 2'd2) ^ gf4_cmul(t[3], 2'd0) ^
                gf4_cmul(t[4], 2'd2) ^ gf4_cmul(t[5], 2'd2);

  assign z[2] = gf4_cmul(t[0], 2'd0) ^ gf4_cmul(t[1], 2'd1) ^
                gf4_cmul(t[2], 2'd3) ^ gf4_cmul(t[3], 2'd1) ^
                gf4_cmul(t[4], 2'd0) ^ gf4_cmul(t[5], 2'd1);

  assign p = {z[2], z[1], z[0]};
  assign y = lin_map(INV_ISO_ROWS, p);

endmodule

/* hdl/sbox_lane.sv */
`timescale 1ns/1ps

module sbox_lane import sbox_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  load,
  input  gf64_t data,
  input  logic  take,
  output logic  busy,
  output gf64_t result
);

  gf64_t power;

  gf64_power40 u_power (
    .x(data),
    .y(power)
  );

  // A lane holds one symbol from load until the collector frees it.
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (load) begin
      busy <= 1'b1;
    end else if (take) begin
      busy <= 1'b0;
    end
  end

  // data is already held stable by the dispatcher, so the power map settles in the load cycle.
  always_ff @(posedge clk) begin
    if (load) begin
      result <= power;  // held until the next load.
    end
  end

endmodule

/* hdl/lane_dispatcher.sv */
`timescale 1ns/1ps

module lane_dispatcher import sbox_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  in_req,
  input  gf64_t in_data,
  output logic  in_ack,
  input  logic  lane_busy [NUM_LANES],
  output logic  load [NUM_LANES],
  output gf64_t lane_data
);

  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    ACK,
    WAIT_RELEASE  // stalled until the collector frees the lane at wr_ptr.
  } disp_state_t;

  disp_state_t state;
  lane_idx_t   wr_ptr;
  logic        lane_free;
  logic        accept;

  assign lane_free = !lane_busy[wr_ptr];
  assign accept = in_req && lane_free && (state == IDLE || state == WAIT_RELEASE);

  assign in_ack = (state == ACK);

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      load[i] = (state == LOAD) && (wr_ptr == lane_idx_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= IDLE;
      wr_ptr <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (in_req) begin
            state <= lane_free ? LOAD : WAIT_RELEASE;
          end
        end
        WAIT_RELEASE: begin
          if (lane_free) begin
            state <= LOAD;
          end
        end
        LOAD: begin
          state  <= ACK;
          wr_ptr <= (wr_ptr == lane_idx_t'(NUM_LANES - 1)) ? '0 : wr_ptr + 1'b1;
        end
        ACK: begin
          if (!in_req) begin
            state <= IDLE;  // ack falls once the source has released req.
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // in_data is stable while in_req is high, so one capture serves the whole load cycle.
  always_ff @(posedge clk) begin
    if (accept) begin
      lane_data <= in_data;
    end
  end

endmodule

/* hdl/lane_collector.sv */
`timescale 1ns/1ps

module lane_collector import sbox_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  lane_busy [NUM_LANES],
  input  gf64_t lane_result [NUM_LANES],
  output logic  take [NUM_LANES],
  output logic  out_req,
  output gf64_t out_data,
  input  logic  out_ack
);

  typedef enum logic [1:0] {
    IDLE,
    OFFER,
    WAIT_RELEASE
  } coll_state_t;

  coll_state_t state;
  lane_idx_t   rd_ptr;
  logic        take_q;
  logic        start;

  // Same round-robin order as the dispatcher, which keeps results in input order.
  assign start = (state == IDLE) && lane_busy[rd_ptr] && !out_ack;

  assign out_req = (state == OFFER);

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      take[i] = take_q && (rd_ptr == lane_idx_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= IDLE;
      rd_ptr <= '0;
      take_q <= 1'b0;
    end else begin
      take_q <= 1'b0;
      if (take_q) begin
        rd_ptr <= (rd_ptr == lane_idx_t'(NUM_LANES - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case (state)
        IDLE: begin
          if (start) begin
            state <= OFFER;
          end
        end
        OFFER: begin
          if (out_ack) begin
            state  <= WAIT_RELEASE;
            take_q <= 1'b1;  // frees the lane while req drops.
          end
        end
        WAIT_RELEASE: begin
          if (!out_ack) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      out_data <= lane_result[rd_ptr];  // stays put for the whole offer.
    end
  end

endmodule

/* hdl/sbox_array_top.sv */
`timescale 1ns/1ps

module sbox_array_top import sbox_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  in_req,
  input  gf64_t in_data,
  output logic  in_ack,
  output logic  out_req,
  output gf64_t out_data,
  input  logic  out_ack
);

  logic  load [NUM_LANES];
  logic  take [NUM_LANES];
  logic  lane_busy [NUM_LANES];
  gf64_t lane_result [NUM_LANES];
  gf64_t lane_data;

  lane_dispatcher u_dispatcher (
    .clk       (clk),
    .reset     (reset),
    .in_req    (in_req),
    .in_data   (in_data),
    .in_ack    (in_ack),
    .lane_busy (lane_busy),
    .load      (load),
    .lane_data (lane_data)
  );

  // every lane sees the same data bus, and only the one with load set captures it.
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    sbox_lane u_lane (
      .clk    (clk),
      .reset  (reset),
      .load   (load[i]),
      .data   (lane_data),
      .take   (take[i]),
      .busy   (lane_busy[i]),
      .result (lane_result[i])
    );
  end

  lane_collector u_collector (
    .clk         (clk),
    .reset       (reset),
    .lane_busy   (lane_busy),
    .lane_result (lane_result),
    .take        (take),
    .out_req     (out_req),
    .out_data    (out_data),
    .out_ack     (out_ack)
  );

endmodule

/* bench/sbox_array_chk.sv */
`timescale 1ns/1ps

module sbox_array_chk import sbox_pkg::*; (
  input logic  clk,
  input logic  reset,
  input logic  in_req,
  input gf64_t in_data,
  input logic  in_ack,
  input logic  out_req,
  input gf64_t out_data,
  input logic  out_ack
);

  // the source holds its symbol until the request is released.
  a_in_data_stable: assert property (@(posedge clk) disable iff (reset)
    in_req |=> !in_req || $stable(in_data))
    else $error("in_data changed while in_req was high");

  a_out_req_held: assert property (@(posedge clk) disable iff (reset)
    out_req && !out_ack |=> out_req)
    else $error("out_req fell before out_ack rose");

  a_out_data_stable: assert property (@(posedge clk) disable iff (reset)
    out_req |=> !out_req || $stable(out_data))
    else $error("out_data changed while out_req was high");

  a_reset_clears: assert property (@(posedge clk)
    $past(reset) |-> !in_ack && !out_req)
    else $error("in_ack or out_req high in the cycle after reset");

endmodule

bind sbox_array_top sbox_array_chk u_chk (
  .clk      (clk),
  .reset    (reset),
  .in_req   (in_req),
  .in_data  (in_data),
  .in_ack   (in_ack),
  .out_req  (out_req),
  .out_data (out_data),
  .out_ack  (out_ack)
);

/* bench/sbox_array_tb.sv */
`timescale 1ns/1ps

module sbox_array_tb import sbox_pkg::*; ();

  localparam int TOTAL_SYMBOLS = 132;  // sweep, burst, back-pressure and reset tests.
  localparam int WATCHDOG_CYCLES = TOTAL_SYMBOLS * 40 + 200;

  // gf(4) constants in the normal basis {g, g^2}, where 1 = g + g^2.
  localparam gf4_t ZERO = 2'b00;
  localparam gf4_t G = 2'b01;
  localparam gf4_t G2 = 2'b10;
  localparam gf4_t ONE = 2'b11;

  // constant rows that combine the six composite-field terms into the output digits.
  localparam gf4_t COEF [3][6] = '{
    '{ONE, G, ZERO, ONE, G, ZERO},
    '{ZERO, G, G, ZERO, G, G},
    '{ZERO, ONE, G2, ONE, ZERO, ONE}
  };

  logic        clk;
  logic        reset;
  logic        in_req;
  gf64_t       in_data;
  logic        in_ack;
  logic        out_req;
  gf64_t       out_data;
  logic        out_ack;
  logic [31:0] lcg_state = 32'd96;
  gf64_t       expected_q [$];
  gf64_t       sym_q [$];
  int          delay_q [$];
  int          accepted = 0;
  int          completed = 0;
  logic        stall_seen = 1'b0;

  sbox_array_top UUT (
    .clk      (clk),
    .reset    (reset),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_data (out_data),
    .out_ack  (out_ack)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // each output bit is the parity of the input bits picked by its row.
  function automatic gf64_t apply_rows(input gf64_t rows [6], input gf64_t a);
    gf64_t r;
    logic  acc;
    r = '0;
    for (int k = 0; k < 6; k++) begin
      acc = 1'b0;
      for (int j = 0; j < 6; j++) begin
        if (rows[k][j]) begin
          acc = acc ^ a[j];
        end
      end
      r[k] = acc;
    end
    return r;
  endfunction

  // gf(4) product done in the polynomial basis {1, g} with g^2 = g + 1.
  function automatic gf4_t gf4_times(input gf4_t a, input gf4_t b);
    logic [1:0] x;
    logic [1:0] y;
    logic [1:0] c;
    x = {a[0] ^ a[1], a[1]};
    y = {b[0] ^ b[1], b[1]};
    c[1] = (x[1] & y[1]) ^ (x[1] & y[0]) ^ (x[0] & y[1]);
    c[0] = (x[1] & y[1]) ^ (x[0] & y[0]);
    return {c[0], c[1] ^ c[0]};  // back to normal-basis coordinates.
  endfunction

  function automatic gf64_t model_power40(input gf64_t x);
    gf64_t w;
    gf4_t  d [3];
    gf4_t  term [6];
    gf4_t  z [3];
    w = apply_rows(ISO_ROWS, x);
    for (int i = 0; i < 3; i++) begin
      d[i] = w[2*i +: 2];
      term[i] = d[i];
    end
    term[3] = gf4_times(gf4_times(d[0], d[0]), gf4_times(d[1], d[1]));
    term[4] = gf4_times(gf4_times(d[0], d[0]), gf4_times(d[2], d[2]));
    term[5] = gf4_times(gf4_times(d[1], d[1]), gf4_times(d[2], d[2]));
    for (int r = 0; r < 3; r++) begin
      z[r] = ZERO;
      for (int j = 0; j < 6; j++) begin
        z[r] = z[r] ^ gf4_times(COEF[r][j], term[j]);
      end
    end
    return apply_rows(INV_ISO_ROWS, {z[2], z[1], z[0]});
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_symbol(input string name, input gf64_t actual, input gf64_t expected);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] %0t ns %s: got %02h, expected %02h",
                         $time, name, actual, expected));
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] %0t ns %s: got %b, expected %b",
                         $time, name, actual, expected));
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic send_symbol(input gf64_t x);
    expected_q.push_back(model_power40(x));
    in_data = x;
    in_req = 1'b1;
    step();
    while (!in_ack) begin
      if (accepted - completed >= NUM_LANES) begin
        stall_seen = 1'b1;  // every lane holds a result the sink has not taken.
      end
      step();
    end
    accepted++;
    check_flag("pending results within lane count", (accepted - completed) <= NUM_LANES, 1'b1);
    in_req = 1'b0;
    step();
    while (in_ack) begin
      step();
    end
  endtask

  task automatic receive_symbol(input int delay, output gf64_t got);
    while (!out_req) begin
      step();
    end
    if (expected_q.size() == 0) begin
      fail_run("a result came out with no symbol outstanding");
    end
    got = out_data;
    check_symbol("out_data", out_data, expected_q.pop_front());
    repeat (delay) begin
      step();
    end
    out_ack = 1'b1;
    completed++;
    while (out_req) begin
      step();
    end
    out_ack = 1'b0;
  endtask

  task automatic send_stream();
    for (int n = 0; n < sym_q.size(); n++) begin
      send_symbol(sym_q[n]);
    end
  endtask

  task automatic receive_stream();
    gf64_t got;
    for (int n = 0; n < delay_q.size(); n++) begin
      receive_symbol(delay_q[n], got);
    end
  endtask

  task automatic run_stream(input int count, input bit slow_sink);
    sym_q.delete();
    delay_q.delete();
    for (int n = 0; n < count; n++) begin
      sym_q.push_back(gf64_t'(lcg_next() >> 26));
      delay_q.push_back(slow_sink ? int'(lcg_next() >> 27) : 0);
    end
    fork
      send_stream();
      receive_stream();
    join
    // a lane left busy would be offered again within two cycles.
    repeat (4) begin
      step();
    end
    check_flag("out_req after the last result", out_req, 1'b0);
  endtask

  task automatic test_after_reset();
    check_flag("in_ack", in_ack, 1'b0);
    check_flag("out_req", out_req, 1'b0);
  endtask

  task automatic test_sweep();
    logic  seen [64];
    gf64_t got;
    for (int v = 0; v < 64; v++) begin
      seen[v] = 1'b0;
    end
    for (int v = 0; v < 64; v++) begin
      send_symbol(gf64_t'(v));
      receive_symbol(0, got);
      if (v == 0) begin
        check_symbol("out_data for 0", got, 6'h00);
      end
      check_flag("output already seen", seen[got], 1'b0);
      seen[got] = 1'b1;
    end
  endtask

  task automatic test_back_pressure();
    stall_seen = 1'b0;
    run_stream(24, 1'b1);
    check_flag("in_ack stalled on full lanes", stall_seen, 1'b1);
  endtask

  task automatic test_reset_mid_burst();
    for (int n = 0; n < 3; n++) begin
      send_symbol(gf64_t'(lcg_next() >> 26));
    end
    while (!out_req) begin
      step();
    end
    in_data = gf64_t'(lcg_next() >> 26);
    in_req = 1'b1;
    step();
    while (!in_ack) begin
      step();
    end
    reset = 1'b1;  // both ports are mid-handshake here.
    in_req = 1'b0;
    step();
    check_flag("in_ack in reset", in_ack, 1'b0);
    check_flag("out_req in reset", out_req, 1'b0);
    step();
    reset = 1'b0;
    expected_q.delete();
    accepted = 0;
    completed = 0;
    test_after_reset();
    run_stream(8, 1'b0);
  endtask

  initial begin
    reset = 1'b1;
    in_req = 1'b0;
    in_data = '0;
    out_ack = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    test_after_reset();
    test_sweep();
    run_stream(32, 1'b0);
    test_back_pressure();
    test_reset_mid_burst();
    $display("** PASS **");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("timeout: the handshakes stopped making progress");
  end

endmodule

/* project.f */
common/sbox_pkg.sv
gf_power/gf64_power40.sv
hdl/sbox_lane.sv
hdl/lane_dispatcher.sv
hdl/lane_collector.sv
hdl/sbox_array_top.sv
bench/sbox_array_chk.sv
bench/sbox_array_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module sbox_array_tb \
  -o sbox_array_sim || exit 1
sim_out="$(./obj_dir/sbox_array_sim 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qF '** PASS **' && exit 0 || exit 1
